//--- build.f
verilog/jag_mem_pkg.sv
verilog/cart_loader.sv
verilog/cart_reader.sv
verilog/dram_bridge.sv
verilog/ddr_port_ctrl.sv
verilog/jag_mem_glue.sv
test/jag_mem_chk.sv
test/tb_jag_mem.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the memory glue testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_jag_mem -f build.f -o sim_jag_mem
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# keep running after assertion errors so the testbench can report
./obj_dir/sim_jag_mem +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- test/jag_mem_chk.sv
// protocol assertions on the memory glue top level, attached with bind
`timescale 1ns/1ps

module jag_mem_chk import jag_mem_pkg::*; (
	input logic        clk_sys,
	input logic        reset,
	input host_load_t  host,
	input logic        loader_en,
	input ddr_req_t    ddr,
	input logic        xwaitl,
	input sdram_req_t  sdram,
	input dram_state_e dram_state,
	input logic        ram_rdy,
	input logic        ch_ready
);

	// failed assertions, the testbench reads this at the end of the run
	int err_cnt = 0;

	// ==============================
	// ddr side
	// ==============================

	// cartridge halfword from the host lands on ddr one cycle later
	a_load_we: assert property (@(posedge clk_sys) disable iff (reset)
		(host.wr && (host.index != 8'd0) && loader_en) |=> ddr.we)
		else begin
			err_cnt = err_cnt + 1;
			$error("host wr during load gave no ddr we on the next cycle");
		end

	// core is put on wait right after a cartridge read goes out
	a_rd_wait: assert property (@(posedge clk_sys) disable iff (reset)
		ddr.rd |=> !xwaitl)
		else begin
			err_cnt = err_cnt + 1;
			$error("ddr rd was not followed by xwaitl low");
		end

	// ==============================
	// sdram side
	// ==============================

	// one request in flight, so req only ever comes out of idle
	a_req_idle: assert property (@(posedge clk_sys) disable iff (reset)
		sdram.req |-> ($past(dram_state) == RAM_IDLE))
		else begin
			err_cnt = err_cnt + 1;
			$error("sdram req raised outside RAM_IDLE");
		end

	// ready to the core comes with the channel and stays up into RAM_END
	a_rdy_follow: assert property (@(posedge clk_sys) disable iff (reset)
		(ch_ready || $past(ch_ready)) |-> ram_rdy)
		else begin
			err_cnt = err_cnt + 1;
			$error("ram_rdy low with ch_ready or on the cycle after it");
		end

endmodule

bind jag_mem_glue jag_mem_chk u_chk (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.host       (host),
	.loader_en  (loader_en),
	.ddr        (ddr),
	.xwaitl     (xwaitl),
	.sdram      (sdram),
	.dram_state (u_dram.state),
	.ram_rdy    (ram_rdy),
	.ch_ready   (ch_ready)
);

//--- test/tb_jag_mem.sv
// testbench top for the memory glue, clock, reset, stimulus, ddr and sdram responders, checks
`timescale 1ns/1ps

module tb_jag_mem import jag_mem_pkg::*; ();

	// run length budget in cycles, one entry per test
	localparam int T_RESET  = 5;
	localparam int T_HOLD   = 40;
	localparam int T_LOAD   = 50;
	localparam int T_RDWAIT = 100;
	localparam int T_HALF   = 125;
	localparam int T_DWR    = 100;
	localparam int T_DRD    = 150;
	localparam int WATCHDOG_CYCLES = T_RESET + T_HOLD + T_LOAD + T_RDWAIT + T_HALF
		+ T_DWR + T_DRD + 200;

	localparam logic [31:0] RNG_SEED = 32'h8f0b;

	logic                   clk_sys;
	logic                   reset;
	host_load_t             host;
	logic [CORE_ADDR_W-1:0] abus;
	logic                   cart_ce_n;
	dram_bus_t              dram;
	ddr_word_u              ddr_dout;
	logic                   ddr_dout_ready;
	logic [63:0]            ch_dout;
	logic                   ch_ready;
	ddr_req_t               ddr;
	sdram_req_t             sdram;
	logic [31:0]            cart_q;
	logic                   xwaitl;
	logic                   ram_rdy;
	logic [63:0]            dram_q;
	logic                   core_reset_n;

	// check counters, t_fail is per test
	int n_pass = 0;
	int n_fail = 0;
	int t_fail = 0;

	logic [31:0] stim_rng = RNG_SEED;

	// loader address the next host write should land on
	logic [23:0] exp_load;

	jag_mem_glue UUT (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.host           (host),
		.abus           (abus),
		.cart_ce_n      (cart_ce_n),
		.dram           (dram),
		.ddr_dout       (ddr_dout),
		.ddr_dout_ready (ddr_dout_ready),
		.ch_dout        (ch_dout),
		.ch_ready       (ch_ready),
		.ddr            (ddr),
		.sdram          (sdram),
		.cart_q         (cart_q),
		.xwaitl         (xwaitl),
		.ram_rdy        (ram_rdy),
		.dram_q         (dram_q),
		.core_reset_n   (core_reset_n)
	);

	// ==============================
	// helpers
	// ==============================
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] next_rand();
		stim_rng = lcg_next(stim_rng);
		return stim_rng;
	endfunction

	// ddr responder word, every address bit shows up twice
	function automatic logic [63:0] ddr_pattern(input logic [28:0] a);
		return {3'b101, a, 3'b010, ~a};
	endfunction

	function automatic logic [63:0] sdram_pattern(input logic [25:0] a);
		return {6'b110010, a, 6'b001101, ~a};
	endfunction

	// lane 0 holds the top two bytes
	function automatic logic [7:0] lane_be(input logic [1:0] lane);
		case (lane)
			2'd0: return 8'hc0;
			2'd1: return 8'h30;
			2'd2: return 8'h0c;
			default: return 8'h03;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) begin
			n_pass++;
		end else begin
			$display("Fail %s expected %h actual %h", name, exp, act);
			n_fail++;
			t_fail++;
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %s finished with %0d failures", name, t_fail);
		t_fail = 0;
	endtask

	// ==============================
	// cartridge side
	// ==============================

	// host strobe, then look at the ddr write one cycle later
	task automatic load_and_check(input string name, input logic [15:0] data);
		logic [15:0] sw;
		sw = {data[7:0], data[15:8]};
		@(posedge clk_sys);
		host.wr <= 1'b1;
		host.data <= data;
		@(posedge clk_sys);
		host.wr <= 1'b0;
		@(negedge clk_sys);
		check_val({name, " we"}, 64'd1, 64'(ddr.we));
		check_val({name, " addr"}, 64'({DDR_REGION, exp_load[23:3]}), 64'(ddr.addr));
		check_val({name, " be"}, 64'(lane_be(exp_load[2:1])), 64'(ddr.be));
		check_val({name, " din"}, {4{sw}}, 64'(ddr.din));
		exp_load = exp_load + 24'd2;
	endtask

	// one cartridge access, either a fresh select or a new address
	task automatic cart_read(input string name, input logic [23:0] addr, input logic drop_ce);
		int n;
		logic seen;
		logic [63:0] exp_word;
		exp_word = ddr_pattern({DDR_REGION, addr[23:3]});
		@(posedge clk_sys);
		abus <= addr;
		if (drop_ce) begin
			cart_ce_n <= 1'b0;
		end
		@(negedge clk_sys);
		check_val({name, " rd"}, 64'd1, 64'(ddr.rd));
		check_val({name, " rd addr"}, 64'({DDR_REGION, addr[23:3]}), 64'(ddr.addr));
		// reads enable every byte lane
		check_val({name, " rd be"}, 64'hff, 64'(ddr.be));
		n = 0;
		seen = 1'b0;
		while (!seen && n < 12) begin
			@(negedge clk_sys);
			check_val({name, " xwaitl low"}, 64'd0, 64'(xwaitl));
			seen = ddr_dout_ready;
			n++;
		end
		if (!seen) begin
			$display("%s: ddr gave no data ready within 12 cycles", name);
			n_fail++;
			t_fail++;
		end
		// wait released exactly one cycle after the data
		@(negedge clk_sys);
		check_val({name, " xwaitl high"}, 64'd1, 64'(xwaitl));
		check_val({name, " cart_q"}, 64'(addr[2] ? exp_word[31:0] : exp_word[63:32]),
			64'(cart_q));
	endtask

	// ==============================
	// main dram side
	// ==============================
	task automatic wait_ch_ready(input string name, input logic is_read, input logic [25:0] addr);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < 12) begin
			@(negedge clk_sys);
			seen = ch_ready;
			n++;
			check_val({name, " ram_rdy"}, 64'(seen), 64'(ram_rdy));
		end
		if (!seen) begin
			$display("%s: sdram channel gave no ch_ready within 12 cycles", name);
			n_fail++;
			t_fail++;
		end else if (is_read) begin
			check_val({name, " dram_q"}, sdram_pattern(addr), dram_q);
		end
		// RAM_END keeps ready up
		@(negedge clk_sys);
		check_val({name, " ram_rdy end"}, 64'd1, 64'(ram_rdy));
	endtask

	task automatic dram_write(input string name);
		logic [31:0] r;
		logic [3:0]  uw;
		logic [3:0]  lw;
		logic [63:0] d;
		logic [23:0] a;
		logic [7:0]  exp_be;
		r = next_rand();
		uw = r[3:0];
		lw = r[7:4];
		if ({uw, lw} == 8'hff) begin
			lw = 4'h0;
		end
		a = r[31:8];
		d = {next_rand(), next_rand()};
		exp_be = {~uw[3], ~lw[3], ~uw[2], ~lw[2], ~uw[1], ~lw[1], ~uw[0], ~lw[0]};
		@(posedge clk_sys);
		abus <= a;
		dram.cas_n <= 1'b0;
		dram.uw_n <= uw;
		dram.lw_n <= lw;
		dram.d <= d;
		@(negedge clk_sys);
		check_val({name, " req early"}, 64'd0, 64'(sdram.req));
		@(negedge clk_sys);
		check_val({name, " req"}, 64'd1, 64'(sdram.req));
		check_val({name, " rnw"}, 64'd0, 64'(sdram.rnw));
		check_val({name, " be"}, 64'(exp_be), 64'(sdram.be));
		check_val({name, " din"}, d, sdram.din);
		check_val({name, " addr"}, 64'({4'b0000, a[22:3], 2'b00}), 64'(sdram.addr));
		wait_ch_ready(name, 1'b0, 26'd0);
		@(posedge clk_sys);
		dram.cas_n <= 1'b1;
		dram.uw_n <= 4'hf;
		dram.lw_n <= 4'hf;
		@(negedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic dram_read(input string name);
		logic [31:0] r;
		logic [3:0]  oe;
		logic [23:0] a;
		logic [25:0] exp_addr;
		r = next_rand();
		oe = r[3:0];
		if (oe == 4'hf) begin
			oe = 4'h7;
		end
		a = r[31:8];
		exp_addr = {4'b0000, a[22:3], 2'b00};
		@(posedge clk_sys);
		abus <= a;
		dram.cas_n <= 1'b0;
		dram.startcas <= 1'b1;
		dram.oe_n <= oe;
		@(posedge clk_sys);
		dram.startcas <= 1'b0;
		@(negedge clk_sys);
		check_val({name, " req"}, 64'd1, 64'(sdram.req));
		check_val({name, " rnw"}, 64'd1, 64'(sdram.rnw));
		check_val({name, " addr"}, 64'(exp_addr), 64'(sdram.addr));
		wait_ch_ready(name, 1'b1, exp_addr);
		// startcas again with cas still low, bridge must hold in RAM_END
		@(posedge clk_sys);
		dram.startcas <= 1'b1;
		@(posedge clk_sys);
		dram.startcas <= 1'b0;
		@(negedge clk_sys);
		check_val({name, " no req in end"}, 64'd0, 64'(sdram.req));
		@(negedge clk_sys);
		check_val({name, " no req in end"}, 64'd0, 64'(sdram.req));
		@(posedge clk_sys);
		dram.cas_n <= 1'b1;
		dram.oe_n <= 4'hf;
		@(negedge clk_sys);
	endtask

	// ==============================
	// clock, responders, watchdog
	// ==============================
	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ddr read responder, 1 to 4 cycles of latency
	initial begin
		int wait_n;
		logic [31:0] ddr_rng;
		logic [28:0] req_addr;
		ddr_rng = lcg_next(RNG_SEED);
		ddr_dout = '0;
		ddr_dout_ready = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (ddr.rd) begin
				ddr_rng = lcg_next(ddr_rng);
				wait_n = 1 + int'(ddr_rng[9:8]);
				req_addr = ddr.addr;
				repeat (wait_n - 1) @(posedge clk_sys);
				ddr_dout <= ddr_pattern(req_addr);
				ddr_dout_ready <= 1'b1;
				@(posedge clk_sys);
				ddr_dout_ready <= 1'b0;
			end
		end
	end

	// sdram channel responder
	initial begin
		int wait_n;
		logic [31:0] ch_rng;
		logic [25:0] req_addr;
		ch_rng = lcg_next(lcg_next(RNG_SEED));
		ch_dout = '0;
		ch_ready = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (sdram.req) begin
				ch_rng = lcg_next(ch_rng);
				wait_n = 1 + int'(ch_rng[9:8]);
				req_addr = sdram.addr;
				repeat (wait_n - 1) @(posedge clk_sys);
				ch_dout <= sdram_pattern(req_addr);
				ch_ready <= 1'b1;
				@(posedge clk_sys);
				ch_ready <= 1'b0;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("watchdog expired, tests still running after %0d cycles", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	// ==============================
	// test sequence
	// ==============================
	initial begin
		int i;
		logic [31:0] r;
		logic [23:0] a;
		reset = 1'b1;
		host = '0;
		abus = '0;
		cart_ce_n = 1'b1;
		dram = '0;
		dram.ras_n = 1'b1;
		dram.cas_n = 1'b1;
		dram.oe_n = 4'hf;
		dram.uw_n = 4'hf;
		dram.lw_n = 4'hf;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (2) @(posedge clk_sys);

		// download of a cartridge image, core held in reset
		exp_load = CART_LOAD_BASE;
		@(posedge clk_sys);
		host.download <= 1'b1;
		host.index <= 8'd1;
		@(negedge clk_sys);
		check_val("download_hold reset", 64'd0, 64'(core_reset_n));
		for (i = 0; i < 4; i++) begin
			r = next_rand();
			load_and_check("download_hold", r[15:0]);
		end
		// cartridge access while loading never reaches ddr
		@(posedge clk_sys);
		cart_ce_n <= 1'b0;
		abus <= 24'h00_1238;
		@(negedge clk_sys);
		check_val("download_hold rd blocked", 64'd0, 64'(ddr.rd));
		@(posedge clk_sys);
		cart_ce_n <= 1'b1;
		@(negedge clk_sys);
		check_val("download_hold reset", 64'd0, 64'(core_reset_n));
		finish_test("download_hold");

		for (i = 0; i < 12; i++) begin
			r = next_rand();
			load_and_check("loader_data", r[31:16]);
		end
		@(posedge clk_sys);
		host.download <= 1'b0;
		@(negedge clk_sys);
		check_val("loader_data reset release", 64'd1, 64'(core_reset_n));
		repeat (2) @(posedge clk_sys);
		finish_test("loader_data");

		// fresh selects
		for (i = 0; i < 5; i++) begin
			r = next_rand();
			cart_read("cart_read_wait", r[23:0], 1'b1);
			@(posedge clk_sys);
			cart_ce_n <= 1'b1;
		end
		finish_test("cart_read_wait");

		// select held low, new addresses alternate the half
		r = next_rand();
		a = r[23:0];
		a[2] = 1'b0;
		cart_read("cart_half_select", a, 1'b1);
		for (i = 0; i < 5; i++) begin
			r = next_rand();
			a = r[23:0];
			a[2] = ~i[0];
			if (a == abus) begin
				a[3] = ~a[3];
			end
			cart_read("cart_half_select", a, 1'b0);
		end
		@(posedge clk_sys);
		cart_ce_n <= 1'b1;
		finish_test("cart_half_select");

		for (i = 0; i < 5; i++) begin
			dram_write("dram_write");
		end
		finish_test("dram_write");

		for (i = 0; i < 5; i++) begin
			dram_read("dram_read_end");
		end
		finish_test("dram_read_end");

		repeat (2) @(posedge clk_sys);
		$display("checks passed %0d, checks failed %0d, assertion failures %0d",
			n_pass, n_fail, UUT.u_chk.err_cnt);
		if (n_fail == 0 && UUT.u_chk.err_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- verilog/cart_loader.sv
// cartridge loader, load address counter, lane byte enables and swapped write data
`timescale 1ns/1ps

module cart_loader import jag_mem_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  host_load_t host,
	input  logic       loader_en,
	input  logic       load_start,
	output ddr_req_t   loader_req
);

	// running byte address, advances one halfword per write
	logic [CORE_ADDR_W-1:0] load_addr;

	// write strobe, one cycle after the host strobe
	logic wr_q;

	// halfword captured with the host strobe
	logic [15:0] wr_data;

	// write word with the swapped halfword in every lane
	ddr_word_u wr_word;

	// ==============================
	// strobe and address counter
	// ==============================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wr_q <= 1'b0;
			load_addr <= CART_LOAD_BASE;
		end else begin
			wr_q <= host.wr & (|host.index);
			if (load_start) begin
				load_addr <= CART_LOAD_BASE;
			end else if (wr_q && loader_en) begin
				// address moves on at the end of the strobe cycle
				load_addr <= load_addr + CORE_ADDR_W'(2);
			end
		end
	end

	// data is held with the strobe, host may change it right after
	always_ff @(posedge clk_sys) begin
		if (host.wr) begin
			wr_data <= host.data;
		end
	end

	// host sends little endian halfwords, ddr wants them swapped
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			wr_word.lane[i] = {wr_data[7:0], wr_data[15:8]};
		end
	end

	// lane from address bits 2:1, lane 0 is the top bytes
	assign loader_req.addr = {DDR_REGION, load_addr[CORE_ADDR_W-1:3]};
	assign loader_req.rd   = 1'b0;
	assign loader_req.we   = wr_q;
	assign loader_req.be   = DDR_BE_LANE0 >> {load_addr[2:1], 1'b0};
	assign loader_req.din  = wr_word;

endmodule

//--- verilog/cart_reader.sv
// cartridge reader, access detect, ddr read strobe, wait line and half select
`timescale 1ns/1ps

module cart_reader import jag_mem_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [CORE_ADDR_W-1:0] abus,
	input  logic                   cart_ce_n,
	input  ddr_word_u              ddr_dout,
	input  logic                   ddr_dout_ready,
	output ddr_req_t               reader_req,
	output logic [31:0]            cart_q,
	output logic                   xwaitl
);

	// chip enable and address from one cycle back
	logic                   ce_n_d;
	logic [CORE_ADDR_W-1:0] abus_d;

	// new cartridge access this cycle
	logic ce_fall;
	logic rd_trig;

	// ==============================
	// access detect
	// ==============================
	assign ce_fall = ce_n_d & ~cart_ce_n;

	// a new access is a fresh select or a new address under a held select
	assign rd_trig = ~cart_ce_n & (ce_fall | (abus != abus_d));

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ce_n_d <= 1'b1;
			abus_d <= '0;
			xwaitl <= 1'b1;
		end else begin
			ce_n_d <= cart_ce_n;
			abus_d <= abus;
			// core waits from the access until the ddr word is back
			if (rd_trig) begin
				xwaitl <= 1'b0;
			end else if (ddr_dout_ready) begin
				xwaitl <= 1'b1;
			end
		end
	end

	// same region mapping as the loader, byte bits 2:0 dropped
	assign reader_req.addr = {DDR_REGION, abus[CORE_ADDR_W-1:3]};
	assign reader_req.rd   = rd_trig;
	assign reader_req.we   = 1'b0;
	assign reader_req.be   = DDR_BE_ALL;
	assign reader_req.din  = '0;

	// 32-bit cartridge width, bit 2 picks the half, clear means upper
	assign cart_q = ddr_dout.half[abus[2]];

endmodule

//--- verilog/ddr_port_ctrl.sv
// download edge detect, loader enable state, core reset hold and ddr request mux
`timescale 1ns/1ps

module ddr_port_ctrl import jag_mem_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  host_load_t host,
	input  ddr_req_t   loader_req,
	input  ddr_req_t   reader_req,
	output logic       loader_en,
	output logic       load_start,
	output logic       core_reset_n,
	output ddr_req_t   ddr
);

	// download level from the previous cycle
	logic download_d;

	// edges of the download level
	logic dl_rise;
	logic dl_fall;

	// ==============================
	// download edges
	// ==============================

	// index 0 is the boot image, only cartridge indexes start the loader
	assign dl_rise = host.download & ~download_d & (|host.index);
	assign dl_fall = ~host.download & download_d;

	// loader rewinds its address in the same cycle the edge is seen
	assign load_start = dl_rise;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			download_d <= 1'b0;
		end else begin
			download_d <= host.download;
		end
	end

	// ==============================
	// loader enable state
	// ==============================

	// set one cycle after the rising edge, cleared one cycle after the falling edge
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			loader_en <= 1'b0;
		end else if (dl_rise) begin
			loader_en <= 1'b1;
		end else if (dl_fall) begin
			loader_en <= 1'b0;
		end
	end

	// core stays in reset for any download, boot image included
	// no register here, the hold follows the level directly
	assign core_reset_n = ~(reset | host.download);

	// ==============================
	// ddr port mux
	// ==============================

	// loader owns the port while loading, reader otherwise
	// the strobe of the side not selected is forced low
	always_comb begin
		if (loader_en) begin
			ddr = loader_req;
			// no cartridge reads while the image is being written
			ddr.rd = 1'b0;
		end else begin
			ddr = reader_req;
			// stray loader strobes never reach ddr outside a load
			ddr.we = 1'b0;
		end
	end

endmodule

//--- verilog/dram_bridge.sv
// main dram bridge, ras/cas strobes to single sdram channel requests
`timescale 1ns/1ps

module dram_bridge import jag_mem_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  dram_bus_t              dram,
	input  logic [CORE_ADDR_W-1:0] abus,
	input  logic [63:0]            ch_dout,
	input  logic                   ch_ready,
	output sdram_req_t             sdram,
	output logic                   ram_rdy,
	output logic [63:0]            dram_q
);

	// request state
	dram_state_e state;

	// request strobe and direction
	logic req_q;
	logic rnw_q;

	// captured with the request
	logic [SDRAM_ADDR_W-1:0] addr_q;
	logic [7:0]              be_q;
	logic [63:0]             din_q;

	// decoded strobes
	logic       rd_cyc;
	logic       wr_cyc;
	logic       start;
	logic [7:0] be_next;

	// ==============================
	// strobe decode
	// ==============================

	// read starts on startcas with any output enable active
	assign rd_cyc = dram.startcas & (dram.oe_n != 4'hf);

	// write is cas low with any write strobe active
	assign wr_cyc = ~dram.cas_n & ({dram.uw_n, dram.lw_n} != 8'hff);

	// only idle accepts a new cycle, one request in flight
	assign start = (state == RAM_IDLE) & (rd_cyc | wr_cyc);

	// be pairs per 16-bit lane, upper byte then lower byte, lane 3 on top
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			be_next[2*i+1] = ~dram.uw_n[i];
			be_next[2*i]   = ~dram.lw_n[i];
		end
	end

	// ==============================
	// request fsm
	// ==============================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= RAM_IDLE;
			req_q <= 1'b0;
			rnw_q <= 1'b1;
		end else begin
			// req is a single-cycle pulse
			req_q <= 1'b0;
			case (state)
				RAM_IDLE: begin
					if (start) begin
						req_q <= 1'b1;
						// write wins when both show up together
						rnw_q <= ~wr_cyc;
						state <= RDY_WAIT;
					end
				end
				RDY_WAIT: begin
					// latency is whatever the channel takes
					if (ch_ready) begin
						state <= RAM_END;
					end
				end
				RAM_END: begin
					// hold until the core ends the cas cycle
					if (dram.cas_n) begin
						state <= RAM_IDLE;
					end
				end
				default: begin
					state <= RAM_IDLE;
				end
			endcase
		end
	end

	// word address and write payload, held for the whole request
	always_ff @(posedge clk_sys) begin
		if (start) begin
			// 64-bit words, burst of four on the 16-bit sdram
			addr_q <= {4'b0000, abus[22:3], 2'b00};
		end
		if (start && wr_cyc) begin
			din_q <= dram.d;
			be_q  <= be_next;
		end
	end

	assign sdram.addr = addr_q;
	assign sdram.rnw  = rnw_q;
	assign sdram.be   = be_q;
	assign sdram.din  = din_q;
	assign sdram.req  = req_q;

	// ready goes out with ch_ready already, not a cycle later
	assign ram_rdy = (state == RAM_END) | ch_ready;
	assign dram_q  = ch_dout;

endmodule

//--- verilog/jag_mem_glue.sv
// top level of the memory glue, ddr port control plus loader, reader and dram bridge
`timescale 1ns/1ps

module jag_mem_glue import jag_mem_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  host_load_t             host,
	input  logic [CORE_ADDR_W-1:0] abus,
	input  logic                   cart_ce_n,
	input  dram_bus_t              dram,
	input  ddr_word_u              ddr_dout,
	input  logic                   ddr_dout_ready,
	input  logic [63:0]            ch_dout,
	input  logic                   ch_ready,
	output ddr_req_t               ddr,
	output sdram_req_t             sdram,
	output logic [31:0]            cart_q,
	output logic                   xwaitl,
	output logic                   ram_rdy,
	output logic [63:0]            dram_q,
	output logic                   core_reset_n
);

	// requests from both cartridge sides, muxed onto the one ddr port
	ddr_req_t loader_req;
	ddr_req_t reader_req;

	// loading state and its start pulse
	logic loader_en;
	logic load_start;

	// ==============================
	// ddr port owner
	// ==============================
	ddr_port_ctrl u_ctrl (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.host         (host),
		.loader_req   (loader_req),
		.reader_req   (reader_req),
		.loader_en    (loader_en),
		.load_start   (load_start),
		.core_reset_n (core_reset_n),
		.ddr          (ddr)
	);

	// cartridge download into ddr
	cart_loader u_loader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.host       (host),
		.loader_en  (loader_en),
		.load_start (load_start),
		.loader_req (loader_req)
	);

	// cartridge reads out of ddr
	cart_reader u_reader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.abus           (abus),
		.cart_ce_n      (cart_ce_n),
		.ddr_dout       (ddr_dout),
		.ddr_dout_ready (ddr_dout_ready),
		.reader_req     (reader_req),
		.cart_q         (cart_q),
		.xwaitl         (xwaitl)
	);

	// main dram lives on the sdram channel
	dram_bridge u_dram (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dram     (dram),
		.abus     (abus),
		.ch_dout  (ch_dout),
		.ch_ready (ch_ready),
		.sdram    (sdram),
		.ram_rdy  (ram_rdy),
		.dram_q   (dram_q)
	);

endmodule

//--- verilog/jag_mem_pkg.sv
// shared localparams, state encoding, ddr word union and bus structs for the memory glue
package jag_mem_pkg;

	// ==============================
	// address map and widths
	// ==============================

	// core bus is a 24-bit byte address
	localparam int CORE_ADDR_W = 24;

	// ddr side takes 64-bit word addresses
	localparam int DDR_ADDR_W = 29;

	// sdram channel word address width
	localparam int SDRAM_ADDR_W = 26;

	// upper ddr field that places the whole core space in ddr
	localparam logic [7:0] DDR_REGION = 8'h30;

	// cartridge image is loaded here (byte address, before the region field)
	localparam logic [CORE_ADDR_W-1:0] CART_LOAD_BASE = 24'h80_0000;

	// ddr controller wants every byte lane enabled on reads
	localparam logic [7:0] DDR_BE_ALL = 8'hff;

	// byte enable of lane 0, the top two bytes of a ddr word
	localparam logic [7:0] DDR_BE_LANE0 = 8'b1100_0000;

	// ==============================
	// main dram bridge states
	// ==============================
	typedef enum logic [1:0] {
		RAM_IDLE = 2'd0,
		RDY_WAIT = 2'd1,
		RAM_END  = 2'd3
	} dram_state_e;

	// one 64-bit ddr word
	// lane view for the loader, half view for cartridge reads
	// index 0 is the most significant part in both views
	typedef union packed {
		logic [0:3][15:0] lane;
		logic [0:1][31:0] half;
	} ddr_word_u;

	// ==============================
	// bus bundles
	// ==============================

	// host download side, wr is a single-cycle strobe
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [7:0]  index;
		logic [15:0] data;
	} host_load_t;

	// request toward the ddr port
	typedef struct packed {
		logic [DDR_ADDR_W-1:0] addr;
		logic                  rd;
		logic                  we;
		logic [7:0]            be;
		ddr_word_u             din;
	} ddr_req_t;

	// ras/cas style strobes from the core dram controller
	typedef struct packed {
		logic        ras_n;
		logic        cas_n;
		logic        startcas;
		logic [3:0]  oe_n;
		logic [3:0]  uw_n;
		logic [3:0]  lw_n;
		logic [63:0] d;
	} dram_bus_t;

	// single request toward the sdram channel
	typedef struct packed {
		logic [SDRAM_ADDR_W-1:0] addr;
		logic                    rnw;
		logic [7:0]              be;
		logic [63:0]             din;
		logic                    req;
	} sdram_req_t;

endpackage
